/* hw/pipe_pkg.sv */
package pipe_pkg;

    // Data path width.
    parameter int xlen = 32;

    // Instruction class as seen by the back end of the pipe.
    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store,
        op_none
    } op_class_e;

    // ALU function; loads and stores use alu_add for the address.
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    // Load width and sign handling.
    typedef enum logic [2:0] {
        ld_b,
        ld_h,
        ld_w,
        ld_bu,
        ld_hu
    } load_kind_e;

    // Decoded operation held in ID.
    typedef struct packed {
        logic             valid;
        op_class_e        op_class;
        alu_op_e          alu_op;
        load_kind_e       load_kind;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic             use_rs1;
        logic             use_rs2;
        logic [4:0]       rd;
        logic [xlen-1:0]  imm;
        logic             use_imm;
    } id_ops_t;

    // EX/MEM register; result is the address for loads and stores.
    typedef struct packed {
        logic             valid;
        op_class_e        op_class;
        load_kind_e       load_kind;
        logic [4:0]       rd;
        logic [xlen-1:0]  result;
        logic [xlen-1:0]  store_data;
    } ex_mem_t;

    // MEM/WB register.
    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [xlen-1:0]  data;
    } mem_wb_t;

endpackage

/* hw/id_decode.sv */
`timescale 1ns/1ps

module id_decode import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic        stall,
    output id_ops_t     id_ops
);

    logic [31:0] instr_q;
    logic        valid_q;

    // Instruction register; it holds while the hazard unit stalls ID.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q <= '0;
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= instr_valid;
            if (instr_valid) begin
                instr_q <= instr;
            end
        end
    end

    // Field decode of the held word.
    always_comb begin
        id_ops           = '0;
        id_ops.valid     = valid_q;
        id_ops.op_class  = op_none;
        id_ops.alu_op    = alu_add;
        id_ops.load_kind = ld_w;
        id_ops.rs1       = instr_q[19:15];
        id_ops.rs2       = instr_q[24:20];
        case (instr_q[6:0])
            // OP-IMM, only ADDI.
            7'b0010011: begin
                if (instr_q[14:12] == 3'b000) begin
                    id_ops.op_class = op_alu;
                    id_ops.use_rs1  = 1'b1;
                    id_ops.use_imm  = 1'b1;
                    id_ops.rd       = instr_q[11:7];
                    id_ops.imm      = {{(xlen-12){instr_q[31]}}, instr_q[31:20]};
                end
            end
            // OP, register-register.
            7'b0110011: begin
                id_ops.op_class = op_alu;
                case ({instr_q[31:25], instr_q[14:12]})
                    10'b0000000_000: id_ops.alu_op = alu_add;
                    10'b0100000_000: id_ops.alu_op = alu_sub;
                    10'b0000000_111: id_ops.alu_op = alu_and;
                    10'b0000000_110: id_ops.alu_op = alu_or;
                    10'b0000000_100: id_ops.alu_op = alu_xor;
                    default:         id_ops.op_class = op_none;
                endcase
                if (id_ops.op_class == op_alu) begin
                    id_ops.use_rs1 = 1'b1;
                    id_ops.use_rs2 = 1'b1;
                    id_ops.rd      = instr_q[11:7];
                end
            end
            // Loads; funct3 picks width and sign.
            7'b0000011: begin
                id_ops.op_class = op_load;
                case (instr_q[14:12])
                    3'b000:  id_ops.load_kind = ld_b;
                    3'b001:  id_ops.load_kind = ld_h;
                    3'b010:  id_ops.load_kind = ld_w;
                    3'b100:  id_ops.load_kind = ld_bu;
                    3'b101:  id_ops.load_kind = ld_hu;
                    default: id_ops.op_class = op_none;
                endcase
                if (id_ops.op_class == op_load) begin
                    id_ops.use_rs1 = 1'b1;
                    id_ops.use_imm = 1'b1;
                    id_ops.rd      = instr_q[11:7];
                    id_ops.imm     = {{(xlen-12){instr_q[31]}}, instr_q[31:20]};
                end
            end
            // Stores, only SW; S-type immediate.
            7'b0100011: begin
                if (instr_q[14:12] == 3'b010) begin
                    id_ops.op_class = op_store;
                    id_ops.use_rs1  = 1'b1;
                    id_ops.use_rs2  = 1'b1;
                    id_ops.use_imm  = 1'b1;
                    id_ops.imm      = {{(xlen-12){instr_q[31]}}, instr_q[31:25],
                                       instr_q[11:7]};
                end
            end
            default: id_ops.op_class = op_none;
        endcase
    end

endmodule

/* hw/id_hazard.sv */
`timescale 1ns/1ps

module id_hazard import pipe_pkg::*; (
    input  id_ops_t id_ops,
    input  ex_mem_t ex_mem,
    output logic    stall
);

    logic ld_in_ex;
    logic hit_rs1;
    logic hit_rs2;

    // A load one stage ahead has no data until MEM/WB.
    // x0 is never a real dependency.
    assign ld_in_ex = ex_mem.valid && (ex_mem.op_class == op_load) && (ex_mem.rd != 5'd0);

    // Only sources the ID operation actually reads count.
    assign hit_rs1 = id_ops.use_rs1 && (id_ops.rs1 == ex_mem.rd);
    assign hit_rs2 = id_ops.use_rs2 && (id_ops.rs2 == ex_mem.rd);

    // One bubble, then MEM/WB forwarding covers the value.
    assign stall = id_ops.valid && ld_in_ex && (hit_rs1 || hit_rs2);

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file import pipe_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  mem_wb_t         wb
);

    // x1..x31 only; x0 has no storage.
    logic [xlen-1:0] regs [1:31];
    logic            wr_en;

    assign wr_en = wb.valid && (wb.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Reads see a write landing in the same cycle.
    always_comb begin
        if (rs1 == 5'd0)                   rs1_data = '0;
        else if (wr_en && (wb.rd == rs1))  rs1_data = wb.data;
        else                               rs1_data = regs[rs1];
        if (rs2 == 5'd0)                   rs2_data = '0;
        else if (wr_en && (wb.rd == rs2))  rs2_data = wb.data;
        else                               rs2_data = regs[rs2];
    end

endmodule

/* hw/ex_alu_stage.sv */
`timescale 1ns/1ps

module ex_alu_stage import pipe_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  id_ops_t         id_ops,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic            stall,
    input  mem_wb_t         wb,
    output ex_mem_t         ex_mem
);

    logic            fwd_ex_ok;
    logic            fwd_wb_ok;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;

    // Only ALU results exist in EX/MEM; a load there stalls ID instead.
    assign fwd_ex_ok = ex_mem.valid && (ex_mem.op_class == op_alu) && (ex_mem.rd != 5'd0);
    assign fwd_wb_ok = wb.valid && (wb.rd != 5'd0);

    // Priority: EX/MEM, then MEM/WB, then the register file.
    always_comb begin
        if (fwd_ex_ok && (ex_mem.rd == id_ops.rs1))  op_a = ex_mem.result;
        else if (fwd_wb_ok && (wb.rd == id_ops.rs1)) op_a = wb.data;
        else                                         op_a = rs1_data;
        if (fwd_ex_ok && (ex_mem.rd == id_ops.rs2))  rs2_val = ex_mem.result;
        else if (fwd_wb_ok && (wb.rd == id_ops.rs2)) rs2_val = wb.data;
        else                                         rs2_val = rs2_data;
    end

    // Immediate replaces rs2 for ADDI and address generation.
    assign op_b = id_ops.use_imm ? id_ops.imm : rs2_val;

    always_comb begin
        case (id_ops.alu_op)
            alu_sub: alu_res = op_a - op_b;
            alu_and: alu_res = op_a & op_b;
            alu_or:  alu_res = op_a | op_b;
            alu_xor: alu_res = op_a ^ op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    // EX/MEM register; a stall leaves a bubble behind.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ops.valid && !stall;
            ex_mem.op_class   <= id_ops.op_class;
            ex_mem.load_kind  <= id_ops.load_kind;
            ex_mem.rd         <= id_ops.rd;
            ex_mem.result     <= alu_res;
            ex_mem.store_data <= rs2_val;
        end
    end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import pipe_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb
);

    // 64 words, word index from address bits 7:2.
    logic [xlen-1:0] dmem [0:63];
    logic [5:0]      widx;
    logic [xlen-1:0] rd_word;
    logic [7:0]      rd_byte;
    logic [15:0]     rd_half;
    logic [xlen-1:0] ld_data;
    logic [xlen-1:0] wb_value;

    assign widx = ex_mem.result[7:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && (ex_mem.op_class == op_store)) begin
            dmem[widx] <= ex_mem.store_data;
        end
    end

    // Combinational read, lane picked by the low address bits.
    assign rd_word = dmem[widx];
    assign rd_byte = rd_word[8*ex_mem.result[1:0] +: 8];
    assign rd_half = ex_mem.result[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (ex_mem.load_kind)
            ld_b:    ld_data = {{(xlen-8){rd_byte[7]}}, rd_byte};
            ld_bu:   ld_data = {{(xlen-8){1'b0}}, rd_byte};
            ld_h:    ld_data = {{(xlen-16){rd_half[15]}}, rd_half};
            ld_hu:   ld_data = {{(xlen-16){1'b0}}, rd_half};
            default: ld_data = rd_word;
        endcase
    end

    // x0 targets still report, but with zero data.
    assign wb_value = (ex_mem.rd == 5'd0) ? '0 :
                      (ex_mem.op_class == op_load) ? ld_data : ex_mem.result;

    // MEM/WB register; stores and unknown ops leave no writeback.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid <= ex_mem.valid &&
                            ((ex_mem.op_class == op_alu) || (ex_mem.op_class == op_load));
            mem_wb.rd    <= ex_mem.rd;
            mem_wb.data  <= wb_value;
        end
    end

endmodule

/* hw/core_pipe_top.sv */
`timescale 1ns/1ps

module core_pipe_top import pipe_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    output logic            instr_ready,
    output logic            wb_valid,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data
);

    id_ops_t         id_ops;
    ex_mem_t         ex_mem;
    mem_wb_t         mem_wb;
    logic            stall;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    // Accept whenever ID is free to move.
    assign instr_ready = ~stall;

    id_decode id_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .id_ops      (id_ops)
    );

    id_hazard id_hazard_inst (
        .id_ops (id_ops),
        .ex_mem (ex_mem),
        .stall  (stall)
    );

    reg_file #(.xlen(xlen)) reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (id_ops.rs1),
        .rs2      (id_ops.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (mem_wb)
    );

    ex_alu_stage #(.xlen(xlen)) ex_alu_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ops   (id_ops),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .stall    (stall),
        .wb       (mem_wb),
        .ex_mem   (ex_mem)
    );

    mem_stage #(.xlen(xlen)) mem_stage_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

    // Writeback port straight from MEM/WB.
    assign wb_valid = mem_wb.valid;
    assign wb_rd    = mem_wb.rd;
    assign wb_data  = mem_wb.data;

endmodule

/* bench/core_pipe_chk.sv */
`timescale 1ns/1ps

module core_pipe_chk (
    input logic clk,
    input logic rst_n,
    input logic stall,
    input logic id_valid,
    input logic instr_valid,
    input logic instr_ready,
    input logic instr_store,
    input logic wb_valid
);

    logic accept;

    // Stores leave no writeback, so they are not followed up.
    assign accept = instr_valid && instr_ready && !instr_store;

    // A stall needs a real operation in ID.
    a_stall_valid: assert property (@(posedge clk) disable iff (!rst_n) stall |-> id_valid)
        else $error("stall high with ID empty");

    // One bubble covers any load-use case.
    a_stall_once: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
        else $error("stall longer than one cycle");

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !wb_valid)
        else $error("writeback during reset");

    // Two cycles after ID when it moves on, three when it stalls once.
    a_wb_fast: assert property (@(posedge clk) disable iff (!rst_n)
        accept ##1 !stall |-> ##2 wb_valid)
        else $error("missing writeback after accept");

    a_wb_slow: assert property (@(posedge clk) disable iff (!rst_n)
        accept ##1 stall |-> ##3 wb_valid)
        else $error("missing writeback after stalled accept");

endmodule

bind core_pipe_top core_pipe_chk core_pipe_chk_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .id_valid    (id_ops.valid),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr_store (instr[6:0] == 7'b0100011),
    .wb_valid    (wb_valid)
);

/* bench/tb_core_pipe.sv */
`timescale 1ns/1ps

module tb_core_pipe;

    typedef struct packed {
        logic [31:0] word;
        logic        gap;
        logic [3:0]  test;
        logic        load_use;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    entry_t      tbl[$];
    logic [36:0] exp_q[$];
    logic [31:0] ref_regs [0:31];
    logic [31:0] ref_mem [0:63];
    logic [31:0] lfsr_state;
    logic [31:0] prev_word;
    logic        have_prev;
    logic [3:0]  build_test;
    logic        table_ready;
    int          errors;
    int          test_errors;
    int          stall_cnt;
    int          exp_stalls;
    int          tests_failed;

    core_pipe_top #(.xlen(32)) core_pipe_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #20 clk = ~clk;

    // Galois LFSR stepped once for each bit taken.
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] rop(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] load(logic [2:0] f3, logic [4:0] rd, logic [11:0] imm);
        return {imm, 5'd0, f3, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // True when the instruction reads register r as a source.
    function automatic logic reads_reg(logic [31:0] w, logic [4:0] r);
        case (w[6:0])
            7'b0110011, 7'b0100011: return (w[19:15] == r) || (w[24:20] == r);
            7'b0010011, 7'b0000011: return w[19:15] == r;
            default:                return 1'b0;
        endcase
    endfunction

    // A load to a nonzero rd read by the very next instruction costs a bubble.
    task automatic add_entry(logic [31:0] w, logic gap);
        entry_t e;
        e.word = w;
        e.gap = gap;
        e.test = build_test;
        e.load_use = have_prev && !gap && (prev_word[6:0] == 7'b0000011) &&
                     (prev_word[11:7] != 5'd0) && reads_reg(w, prev_word[11:7]);
        tbl.push_back(e);
        prev_word = w;
        have_prev = 1'b1;
    endtask

    task automatic start_test(logic [3:0] t);
        build_test = t;
        have_prev = 1'b0;
    endtask

    task automatic build_table();
        logic [2:0] kind;
        logic [4:0] rd;
        logic [4:0] ra;
        logic [4:0] rb;
        // ALU chain with back-to-back and one-apart dependencies.
        start_test(1);
        add_entry(addi(5'd1, 5'd0, 12'h123), 0);
        add_entry(addi(5'd2, 5'd1, 12'hff0), 0);
        add_entry(rop(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 0);
        add_entry(rop(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 0);
        add_entry(rop(7'h00, 3'b111, 5'd5, 5'd4, 5'd3), 0);
        add_entry(rop(7'h00, 3'b110, 5'd6, 5'd5, 5'd2), 0);
        add_entry(rop(7'h00, 3'b100, 5'd7, 5'd6, 5'd3), 0);
        add_entry(rop(7'h00, 3'b100, 5'd1, 5'd7, 5'd3), 0);
        // Store then loads at every lane; one word with negative bytes.
        start_test(2);
        add_entry(addi(5'd1, 5'd0, 12'h8a3), 0);
        add_entry(sw(5'd1, 12'd16), 0);
        add_entry(addi(5'd2, 5'd0, 12'h17f), 0);
        add_entry(sw(5'd2, 12'd20), 0);
        for (int off = 0; off < 4; off++) begin
            add_entry(load(3'b000, 5'd3, 12'd16 + off), 0);
            add_entry(load(3'b100, 5'd4, 12'd16 + off), 0);
            add_entry(load(3'b000, 5'd5, 12'd20 + off), 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            add_entry(load(3'b001, 5'd6, 12'd16 + off), 0);
            add_entry(load(3'b101, 5'd7, 12'd16 + off), 0);
            add_entry(load(3'b001, 5'd6, 12'd20 + off), 0);
        end
        add_entry(load(3'b010, 5'd3, 12'd16), 0);
        add_entry(load(3'b010, 5'd4, 12'd20), 0);
        // Load-use costs one bubble and unrelated or gapped users cost none.
        start_test(3);
        add_entry(addi(5'd5, 5'd0, 12'h321), 0);
        add_entry(sw(5'd5, 12'd32), 0);
        add_entry(load(3'b010, 5'd6, 12'd32), 0);
        add_entry(rop(7'h00, 3'b000, 5'd7, 5'd6, 5'd6), 0);
        add_entry(load(3'b010, 5'd6, 12'd32), 0);
        add_entry(addi(5'd8, 5'd0, 12'd5), 0);
        add_entry(load(3'b010, 5'd9, 12'd32), 0);
        add_entry(rop(7'h00, 3'b000, 5'd10, 5'd9, 5'd5), 1);
        // x0 as destination, and as source right after ALU and load writes to it.
        start_test(4);
        add_entry(addi(5'd0, 5'd0, 12'd55), 0);
        add_entry(addi(5'd12, 5'd0, 12'd7), 0);
        add_entry(load(3'b010, 5'd0, 12'd32), 0);
        add_entry(rop(7'h00, 3'b000, 5'd11, 5'd0, 5'd0), 0);
        // Random mix over x1..x7.
        start_test(5);
        for (int i = 0; i < 40; i++) begin
            kind = rand_bits(3);
            rd = 5'(rand_bits(3) % 7 + 1);
            ra = 5'(rand_bits(3) % 7 + 1);
            rb = 5'(rand_bits(3) % 7 + 1);
            case (kind)
                3'd0: add_entry(rop(7'h00, 3'b000, rd, ra, rb), rand_bits(1));
                3'd1: add_entry(rop(7'h20, 3'b000, rd, ra, rb), rand_bits(1));
                3'd2: add_entry(rop(7'h00, 3'b111, rd, ra, rb), rand_bits(1));
                3'd3: add_entry(rop(7'h00, 3'b110, rd, ra, rb), rand_bits(1));
                3'd4: add_entry(rop(7'h00, 3'b100, rd, ra, rb), rand_bits(1));
                3'd5: add_entry(addi(rd, ra, 12'(rand_bits(12))), rand_bits(1));
                3'd6: add_entry(sw(rb, {4'd0, 6'(rand_bits(6)), 2'b00}), rand_bits(1));
                default: add_entry(load(3'b010, rd, {4'd0, 6'(rand_bits(6)), 2'b00}),
                                   rand_bits(1));
            endcase
        end
    endtask

    // Reference model of one accepted instruction's architectural effect.
    task automatic ref_accept(logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] res;
        logic [7:0]  by;
        logic [15:0] hw;
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        res = '0;
        if (w[6:0] == 7'b0100011) begin
            addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
            ref_mem[addr[7:2]] = b;
            return;
        end
        case (w[6:0])
            7'b0010011: res = a + {{20{w[31]}}, w[31:20]};
            7'b0110011: begin
                case ({w[30], w[14:12]})
                    4'b1000: res = a - b;
                    4'b0111: res = a & b;
                    4'b0110: res = a | b;
                    4'b0100: res = a ^ b;
                    default: res = a + b;
                endcase
            end
            default: begin
                addr = a + {{20{w[31]}}, w[31:20]};
                word = ref_mem[addr[7:2]];
                by = word >> (8 * addr[1:0]);
                hw = word >> (16 * addr[1]);
                case (w[14:12])
                    3'b000:  res = {{24{by[7]}}, by};
                    3'b100:  res = {24'd0, by};
                    3'b001:  res = {{16{hw[15]}}, hw};
                    3'b101:  res = {16'd0, hw};
                    default: res = word;
                endcase
            end
        endcase
        if (w[11:7] == 5'd0) res = '0;
        else ref_regs[w[11:7]] = res;
        exp_q.push_back({w[11:7], res});
    endtask

    // Writeback monitor sampled mid-cycle.
    always @(negedge clk) begin
        logic [36:0] e;
        if (rst_n && !instr_ready) stall_cnt++;
        if (rst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR %0t: writeback rd=%0d with nothing expected", $time, wb_rd);
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                if (wb_rd != e[36:32] || wb_data != e[31:0]) begin
                    $display("ERROR %0t: writeback rd=%0d data=%h, expected rd=%0d data=%h",
                             $time, wb_rd, wb_data, e[36:32], e[31:0]);
                    test_errors++;
                end
            end
        end
    end

    task automatic finish_test(logic [3:0] t);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (3) @(posedge clk);
        #2;
        if (stall_cnt != exp_stalls) begin
            $display("ERROR %0t: test %0d saw %0d stall cycles, expected %0d",
                     $time, t, stall_cnt, exp_stalls);
            test_errors++;
        end
        if (test_errors == 0) begin
            $display("test %0d: ok", t);
        end else begin
            $display("test %0d: %0d errors", t, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
        stall_cnt = 0;
        exp_stalls = 0;
    endtask

    // Watchdog sized from the table.
    initial begin
        longint limit;
        wait (table_ready);
        limit = (tbl.size() + 10 + 50) * 2 * 40;
        #(limit);
        $display("Run timed out before all writebacks arrived");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [3:0] cur_test;
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        errors = 0;
        test_errors = 0;
        stall_cnt = 0;
        exp_stalls = 0;
        tests_failed = 0;
        lfsr_state = 32'h1a5a_3f32;
        table_ready = 1'b0;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        for (int i = 0; i < 64; i++) ref_mem[i] = '0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        cur_test = tbl[0].test;
        foreach (tbl[i]) begin
            if (tbl[i].test != cur_test) begin
                finish_test(cur_test);
                cur_test = tbl[i].test;
            end
            if (tbl[i].gap) begin
                instr_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            if (tbl[i].load_use) exp_stalls++;
            instr_valid = 1'b1;
            instr = tbl[i].word;
            while (!instr_ready) begin
                @(posedge clk);
                #2;
            end
            // Ready is high here so the coming edge accepts the word.
            ref_accept(tbl[i].word);
            @(posedge clk);
            #2;
            instr_valid = 1'b0;
        end
        finish_test(cur_test);
        $display("%0d tests, %0d failed, %0d errors", 5, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
hw/pipe_pkg.sv
hw/id_decode.sv
hw/id_hazard.sv
hw/reg_file.sv
hw/ex_alu_stage.sv
hw/mem_stage.sv
hw/core_pipe_top.sv
bench/core_pipe_chk.sv
bench/tb_core_pipe.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_core_pipe -f list.f -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failures found" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
